// File: filelist.f
hdl/exe_pkg.sv
hdl/exe_alu.sv
hdl/exe_branch.sv
hdl/exe_unit.sv
hdl/exe_pipe_reg.sv
hdl/exe_stage.sv
tb/exe_stage_asserts.sv
tb/exe_stage_tb.sv

// File: Makefile
TOP = exe_stage_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: tb/exe_stage_tb.sv
// testbench for the execute stage
// table of directed cases, then random alu cases checked against a reference model
`default_nettype none

module exe_stage_tb
  import exe_pkg::*;
;

  localparam logic [XLEN-1:0] MIN  = 64'h8000_0000_0000_0000;
  localparam logic [XLEN-1:0] NEG1 = 64'hffff_ffff_ffff_ffff;
  localparam int              N_RAND = 40;

  logic    clk;
  logic    rst;
  logic    i_valid;
  ex_req_t i_req;
  logic    o_valid;
  ex_res_t o_res;

  ex_req_t tab_req[$];
  ex_res_t tab_exp[$];
  ex_res_t exp_q[$];
  int      cyc_q[$];
  ex_res_t exp_head;
  int      cyc_head;
  int      cyc;

  exe_stage UUT (
    .clk     (clk),
    .rst     (rst),
    .i_valid (i_valid),
    .i_req   (i_req),
    .o_valid (o_valid),
    .o_res   (o_res)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin
    cyc = 0;
  end

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  task automatic abort(input string msg);
    $display("error at %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [XLEN-1:0] got,
                       input logic [XLEN-1:0] want);
    if (got !== want)
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
      $display("TEST FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic compare_res(input ex_res_t got, input ex_res_t want);
    check("o_res.rd_wen", 64'(got.rd_wen), 64'(want.rd_wen));
    check("o_res.rd_data", got.rd_data, want.rd_data);
    check("o_res.pc_jmp", 64'(got.pc_jmp), 64'(want.pc_jmp));
    check("o_res.pc_jmpaddr", got.pc_jmpaddr, want.pc_jmpaddr);
    check("o_res.memren", 64'(got.memren), 64'(want.memren));
    check("o_res.memwen", 64'(got.memwen), 64'(want.memwen));
  endtask

  // one directed case whose expected memory enables echo the request's
  task automatic add_case(input ex_class_e cls, input logic [2:0] f3, input logic alt,
                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                          input logic [XLEN-1:0] t, input logic [1:0] mem,
                          input logic wen, input logic [XLEN-1:0] data,
                          input logic jmp, input logic [XLEN-1:0] addr);
    ex_req_t req;
    ex_res_t want;
    req = '{cls: cls, funct3: f3, alt: alt, op1: a, op2: b, t1: t,
            memren: mem[1], memwen: mem[0]};
    want = '{rd_wen: wen, rd_data: data, pc_jmp: jmp, pc_jmpaddr: addr,
             memren: mem[1], memwen: mem[0]};
    tab_req.push_back(req);
    tab_exp.push_back(want);
  endtask

  task automatic fill_table();
    add_case(CLS_OP,     F3_ADD,  0, 5, 7, 0, 2'b00, 1, 64'hc, 0, 0);
    add_case(CLS_OP,     F3_ADD,  1, 5, 7, 0, 2'b00, 1, 64'hffff_ffff_ffff_fffe, 0, 0);
    add_case(CLS_OP,     F3_SLT,  0, MIN, NEG1, 0, 2'b00, 1, 1, 0, 0);
    add_case(CLS_OP,     F3_SLTU, 0, NEG1, 1, 0, 2'b00, 1, 0, 0, 0);
    add_case(CLS_OP,     F3_XOR,  0, 'hf0f0, 'hff00, 0, 2'b00, 1, 'h0ff0, 0, 0);
    add_case(CLS_OP,     F3_OR,   0, 'hf0f0, 'hff00, 0, 2'b00, 1, 'hfff0, 0, 0);
    add_case(CLS_OP,     F3_AND,  0, 'hf0f0, 'hff00, 0, 2'b00, 1, 'hf000, 0, 0);
    // only the low 6 bits of op2 count
    add_case(CLS_OP,     F3_SLL,  0, 1, 'h7f, 0, 2'b00, 1, MIN, 0, 0);
    add_case(CLS_OP,     F3_SRL,  0, MIN, 4, 0, 2'b00, 1, 64'h0800_0000_0000_0000, 0, 0);
    add_case(CLS_OP,     F3_SRL,  1, MIN, 4, 0, 2'b00, 1, 64'hf800_0000_0000_0000, 0, 0);
    add_case(CLS_OPI,    F3_ADD,  0, NEG1, 1, 0, 2'b00, 1, 0, 0, 0);
    add_case(CLS_OPI,    F3_SRL,  1, MIN, 63, 0, 2'b00, 1, NEG1, 0, 0);
    // bit 31 of a word result fills the upper half
    add_case(CLS_OPW,    F3_ADD,  0, 'h7fff_ffff, 1, 0, 2'b00, 1, 64'hffff_ffff_8000_0000, 0, 0);
    add_case(CLS_OPW,    F3_ADD,  1, 0, 1, 0, 2'b00, 1, NEG1, 0, 0);
    add_case(CLS_OPW,    F3_SLL,  0, 1, 'h3f, 0, 2'b00, 1, 64'hffff_ffff_8000_0000, 0, 0);
    add_case(CLS_OPW,    F3_SRL,  0, 64'h8000_0000, 'h20, 0, 2'b00, 1,
             64'hffff_ffff_8000_0000, 0, 0);
    add_case(CLS_OPW,    F3_SRL,  0, NEG1, 'h21, 0, 2'b00, 1, 'h7fff_ffff, 0, 0);
    add_case(CLS_OPW,    F3_SRL,  1, 64'h8000_0000, 4, 0, 2'b00, 1,
             64'hffff_ffff_f800_0000, 0, 0);
    add_case(CLS_OPIW,   F3_ADD,  0, 64'h1234_0000_0000_0005, NEG1, 0, 2'b00, 1, 4, 0, 0);
    add_case(CLS_LUI,    F3_ADD,  0, 64'hffff_ffff_8000_0000, 0, 0, 2'b00, 1,
             64'hffff_ffff_8000_0000, 0, 0);
    add_case(CLS_AUIPC,  F3_ADD,  0, 'h1000, 'h2000, 0, 2'b00, 1, 'h3000, 0, 0);
    add_case(CLS_JAL,    F3_ADD,  0, 'h1004, 'h2000, 0, 2'b00, 1, 'h1004, 1, 'h2000);
    add_case(CLS_JALR,   F3_ADD,  0, 'h3001, 'h10, 'h2004, 2'b00, 1, 'h2004, 1, 'h3010);
    // branches keep rd off and show t1 as target either way
    add_case(CLS_BRANCH, F3_BEQ,  0, 3, 3, 'h400, 2'b00, 0, 0, 1, 'h400);
    add_case(CLS_BRANCH, F3_BEQ,  0, 3, 4, 'h400, 2'b00, 0, 0, 0, 'h400);
    add_case(CLS_BRANCH, F3_BNE,  0, 3, 4, 'h404, 2'b00, 0, 0, 1, 'h404);
    add_case(CLS_BRANCH, F3_BNE,  0, 3, 3, 'h404, 2'b00, 0, 0, 0, 'h404);
    add_case(CLS_BRANCH, F3_BLT,  0, NEG1, 1, 'h408, 2'b00, 0, 0, 1, 'h408);
    add_case(CLS_BRANCH, F3_BLT,  0, 1, NEG1, 'h408, 2'b00, 0, 0, 0, 'h408);
    add_case(CLS_BRANCH, F3_BGE,  0, 1, NEG1, 'h40c, 2'b00, 0, 0, 1, 'h40c);
    add_case(CLS_BRANCH, F3_BGE,  0, MIN, NEG1, 'h40c, 2'b00, 0, 0, 0, 'h40c);
    add_case(CLS_BRANCH, F3_BLTU, 0, 1, NEG1, 'h410, 2'b00, 0, 0, 1, 'h410);
    add_case(CLS_BRANCH, F3_BLTU, 0, NEG1, 1, 'h410, 2'b00, 0, 0, 0, 'h410);
    add_case(CLS_BRANCH, F3_BGEU, 0, NEG1, 1, 'h414, 2'b00, 0, 0, 1, 'h414);
    add_case(CLS_BRANCH, F3_BGEU, 0, 1, NEG1, 'h414, 2'b00, 0, 0, 0, 'h414);
    add_case(CLS_LOAD,   F3_ADD,  0, 'h80, 'h8, 0, 2'b10, 1, 0, 0, 0);
    add_case(CLS_STORE,  F3_ADD,  0, 'h80, 'h8, 0, 2'b01, 0, 0, 0, 0);
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // reference for the integer and word classes
  function automatic ex_res_t model(input ex_req_t r);
    ex_res_t         res;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] v;
    logic [XLEN-1:0] src;
    logic [5:0]      sh;
    logic            is_w;
    logic            sub;
    logic            fill;
    res  = '0;
    a    = r.op1;
    b    = r.op2;
    is_w = (r.cls == CLS_OPW) || (r.cls == CLS_OPIW);
    sub  = r.alt && ((r.cls == CLS_OP) || (r.cls == CLS_OPW));
    sh   = is_w ? {1'b0, b[4:0]} : b[5:0];
    fill = r.alt && (is_w ? a[31] : a[63]);
    src  = is_w ? {{32{fill}}, a[31:0]} : a;
    case (r.funct3)
      F3_ADD:  v = sub ? a + ~b + 64'd1 : a + b;
      F3_SLL:  v = a << sh;
      // signed compare by flipping the sign bits
      F3_SLT:  v = {63'd0, (a ^ MIN) < (b ^ MIN)};
      F3_SLTU: v = {63'd0, a < b};
      F3_XOR:  v = a ^ b;
      F3_SRL:  v = (src >> sh) | (fill ? ~(NEG1 >> sh) : 64'd0);
      F3_OR:   v = a | b;
      default: v = a & b;
    endcase
    res.rd_wen  = 1'b1;
    res.rd_data = is_w ? {{32{v[31]}}, v[31:0]} : v;
    res.memren  = r.memren;
    res.memwen  = r.memwen;
    return res;
  endfunction

  // drive one item plus one wrong-path item after a jump
  task automatic issue(input ex_req_t req, input ex_res_t want);
    ex_req_t wrong;
    // wrong-path item is itself a jump whose dead slot must not squash the next item
    wrong        = '0;
    wrong.cls    = CLS_JAL;
    wrong.op2    = 'h800;
    i_valid      = 1'b1;
    i_req        = req;
    exp_q.push_back(want);
    cyc_q.push_back(cyc);
    @(posedge clk);
    #1;
    if (want.pc_jmp)
    begin
      i_req = wrong;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_random();
    logic [31:0] seed;
    logic [31:0] ctl;
    ex_req_t     req;
    seed = 32'h1fdb_f8b8;
    for (int k = 0; k < N_RAND; k++)
    begin
      seed = xorshift(seed);
      ctl  = seed;
      seed = xorshift(seed);
      req.op1[63:32] = seed;
      seed = xorshift(seed);
      req.op1[31:0] = seed;
      seed = xorshift(seed);
      req.op2 = {seed, xorshift(seed)};
      seed = xorshift(seed);
      // bias toward the signed corner values
      if (ctl[9:8] == 2'b00)
        req.op1 = MIN;
      if (ctl[11:10] == 2'b00)
        req.op2 = NEG1;
      case (ctl[1:0])
        2'd0:    req.cls = CLS_OP;
        2'd1:    req.cls = CLS_OPI;
        2'd2:    req.cls = CLS_OPW;
        default: req.cls = CLS_OPIW;
      endcase
      req.funct3 = ctl[4:2];
      req.alt    = ctl[5];
      req.t1     = '0;
      req.memren = ctl[6];
      req.memwen = ctl[7];
      // word space has add, sll and srl only
      if (ctl[1] && !(req.funct3 inside {F3_ADD, F3_SLL, F3_SRL}))
        req.funct3 = F3_ADD;
      issue(req, model(req));
    end
  endtask

  // output monitor samples mid-cycle
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (o_valid)
      begin
        if (exp_q.size() == 0)
        begin
          abort("o_valid seen with no item in flight");
        end
        else
        begin
          exp_head = exp_q.pop_front();
          cyc_head = cyc_q.pop_front();
          check("latency", 64'(cyc - cyc_head), 64'd2);
          compare_res(o_res, exp_head);
        end
      end
      else if ((cyc_q.size() != 0) && (cyc >= cyc_q[0] + 2))
      begin
        abort("an issued item never raised o_valid");
      end
    end
  end

  initial
  begin
    #1;
    // each table entry may add a wrong-path cycle
    #((2 * tab_req.size() + N_RAND + 20) * 8);
    $display("error: watchdog expired before the tests finished");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  initial
  begin
    rst     = 1'b1;
    i_valid = 1'b0;
    i_req   = '0;
    fill_table();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check("o_valid", 64'(o_valid), 64'd0);
    compare_res(o_res, '0);
    @(posedge clk);
    #1;
    for (int i = 0; i < tab_req.size(); i++)
      issue(tab_req[i], tab_exp[i]);
    run_random();
    i_valid = 1'b0;
    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (2) @(negedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/exe_stage_asserts.sv
// valid, reset and squash properties of the execute stage
`default_nettype none

module exe_stage_asserts
  import exe_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic i_valid,
  input logic i_jmp,
  input logic i_out_valid
);

  // reset empties the output slot
  a_reset_clears: assert property (@(posedge clk) rst |=> !i_out_valid)
    else $error("o_valid high in the cycle after reset");

  // plain item leaves two edges after it was taken in
  a_latency: assert property (@(posedge clk) disable iff (rst)
      (!$past(rst, 1) && !$past(rst, 2) && $past(i_valid, 2) && !$past(i_jmp, 2))
      |-> i_out_valid)
    else $error("o_valid missing two cycles after i_valid");

  // wrong-path item behind a jump
  a_squash: assert property (@(posedge clk) disable iff (rst)
      (!$past(rst, 1) && !$past(rst, 2) && $past(i_valid, 2) && $past(i_jmp, 2))
      |-> !i_out_valid)
    else $error("squashed slot raised o_valid");

endmodule

bind exe_stage exe_stage_asserts u_asserts (
  .clk         (clk),
  .rst         (rst),
  .i_valid     (i_valid),
  .i_jmp       (unit_res.pc_jmp),
  .i_out_valid (o_valid)
);

`default_nettype wire

// File: hdl/exe_stage.sv
// execute stage top
// input register, execute unit, output register, two-cycle latency
`default_nettype none

module exe_stage
  import exe_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     i_valid,
  input  ex_req_t  i_req,
  output logic     o_valid,
  output ex_res_t  o_res
);

  logic    req_valid;
  ex_req_t req_q;
  ex_res_t unit_res;

  // first register, holds the decoded request
  // a jump in this slot kills the wrong-path item arriving behind it
  exe_pipe_reg #(
    .T_PAYLOAD (ex_req_t)
  ) u_req_reg (
    .clk     (clk),
    .rst     (rst),
    .i_valid (i_valid),
    .i_kill  (unit_res.pc_jmp),
    .i_data  (i_req),
    .o_valid (req_valid),
    .o_data  (req_q)
  );

  exe_unit u_unit (
    .i_valid (req_valid),
    .i_req   (req_q),
    .o_res   (unit_res)
  );

  // second register, holds the result
  // never squashed here
  exe_pipe_reg #(
    .T_PAYLOAD (ex_res_t)
  ) u_res_reg (
    .clk     (clk),
    .rst     (rst),
    .i_valid (req_valid),
    .i_kill  (1'b0),
    .i_data  (unit_res),
    .o_valid (o_valid),
    .o_data  (o_res)
  );

endmodule

`default_nettype wire

// File: hdl/exe_pipe_reg.sv
// stage register with valid bit and squash, any payload type
`default_nettype none

module exe_pipe_reg #(
  parameter type T_PAYLOAD = logic
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      i_valid,
  input  logic      i_kill,
  input  T_PAYLOAD  i_data,
  output logic      o_valid,
  output T_PAYLOAD  o_data
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      o_valid <= 1'b0;
      o_data  <= T_PAYLOAD'('0);
    end
    else
    begin
      // killed item still loads, just marked invalid
      o_valid <= i_valid & ~i_kill;
      // bubble keeps the last payload
      if (i_valid)
        o_data <= i_data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/exe_unit.sv
// combinational execute unit
// joins alu and branch logic into one stage result
`default_nettype none

module exe_unit
  import exe_pkg::*;
(
  input  logic     i_valid,
  input  ex_req_t  i_req,
  output ex_res_t  o_res
);

  logic [XLEN-1:0] alu_data;
  logic            br_jmp;
  logic [XLEN-1:0] br_jmpaddr;
  logic            rd_wen;

  exe_alu u_alu (
    .i_req  (i_req),
    .o_data (alu_data)
  );

  exe_branch u_branch (
    .i_req     (i_req),
    .o_jmp     (br_jmp),
    .o_jmpaddr (br_jmpaddr)
  );

  // classes that write rd
  always_comb
  begin
    case (i_req.cls)
      CLS_LUI,
      CLS_AUIPC,
      CLS_OPI,
      CLS_OP,
      CLS_OPIW,
      CLS_OPW,
      CLS_JAL,
      CLS_JALR,
      CLS_LOAD: rd_wen = 1'b1;
      // branch, store, none
      default:  rd_wen = 1'b0;
    endcase
  end

  // empty or squashed slot gives an all-zero result
  // so no stray pc_jmp leaves the stage
  always_comb
  begin
    if (!i_valid)
    begin
      o_res = '0;
    end
    else
    begin
      o_res.rd_wen     = rd_wen;
      o_res.rd_data    = alu_data;
      o_res.pc_jmp     = br_jmp;
      o_res.pc_jmpaddr = br_jmpaddr;
      // memory enables just ride along
      o_res.memren     = i_req.memren;
      o_res.memwen     = i_req.memwen;
    end
  end

endmodule

`default_nettype wire

// File: hdl/exe_branch.sv
// branch condition and jump target for the execute stage
`default_nettype none

module exe_branch
  import exe_pkg::*;
(
  input  ex_req_t          i_req,
  output logic             o_jmp,
  output logic [XLEN-1:0]  o_jmpaddr
);

  logic [XLEN-1:0] jalr_sum;
  logic            br_cond;

  // base + offset, bit 0 dropped below
  assign jalr_sum = i_req.op1 + i_req.op2;

  // compare op1 against op2 per funct3
  always_comb
  begin
    case (i_req.funct3)
      F3_BEQ:  br_cond = (i_req.op1 == i_req.op2);
      F3_BNE:  br_cond = (i_req.op1 != i_req.op2);
      F3_BLT:  br_cond = ($signed(i_req.op1) <  $signed(i_req.op2));
      F3_BGE:  br_cond = ($signed(i_req.op1) >= $signed(i_req.op2));
      F3_BLTU: br_cond = (i_req.op1 <  i_req.op2);
      F3_BGEU: br_cond = (i_req.op1 >= i_req.op2);
      // 010 and 011 are not branches
      default: br_cond = 1'b0;
    endcase
  end

  always_comb
  begin
    case (i_req.cls)
      CLS_JAL:
      begin
        o_jmp     = 1'b1;
        o_jmpaddr = i_req.op2;
      end
      CLS_JALR:
      begin
        o_jmp     = 1'b1;
        o_jmpaddr = {jalr_sum[XLEN-1:1], 1'b0};
      end
      CLS_BRANCH:
      begin
        // target shows even when not taken
        o_jmp     = br_cond;
        o_jmpaddr = i_req.t1;
      end
      default:
      begin
        o_jmp     = 1'b0;
        o_jmpaddr = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/exe_alu.sv
// integer alu for the execute stage
// 64-bit ops, W variants with sign extension, lui/auipc and link values
`default_nettype none

module exe_alu
  import exe_pkg::*;
(
  input  ex_req_t          i_req,
  output logic [XLEN-1:0]  o_data
);

  logic [XLEN-1:0]   op1;
  logic [XLEN-1:0]   op2;
  logic [5:0]        shamt;
  logic [4:0]        shamt_w;
  logic [W_XLEN-1:0] op1_w;
  logic [W_XLEN-1:0] op2_w;
  logic              is_sub;
  logic              is_sub_w;
  logic [XLEN-1:0]   int_res;
  logic [W_XLEN-1:0] word_res;

  assign op1     = i_req.op1;
  assign op2     = i_req.op2;
  // immediate shifts carry shamt in op2 as well
  assign shamt   = op2[5:0];
  assign shamt_w = op2[4:0];
  assign op1_w   = op1[W_XLEN-1:0];
  assign op2_w   = op2[W_XLEN-1:0];

  // sub only exists in register-register form
  assign is_sub   = i_req.alt && (i_req.cls == CLS_OP);
  assign is_sub_w = i_req.alt && (i_req.cls == CLS_OPW);

  // full width result, op and opi
  always_comb
  begin
    int_res = '0;
    case (i_req.funct3)
      F3_ADD:
      begin
        if (is_sub)
          int_res = op1 - op2;
        else
          int_res = op1 + op2;
      end
      F3_SLL:  int_res = op1 << shamt;
      F3_SLT:  int_res = {{(XLEN-1){1'b0}}, ($signed(op1) < $signed(op2))};
      F3_SLTU: int_res = {{(XLEN-1){1'b0}}, (op1 < op2)};
      F3_XOR:  int_res = op1 ^ op2;
      F3_SRL:
      begin
        // kept as if/else so >>> stays arithmetic
        if (i_req.alt)
          int_res = $signed(op1) >>> shamt;
        else
          int_res = op1 >> shamt;
      end
      F3_OR:   int_res = op1 | op2;
      F3_AND:  int_res = op1 & op2;
      default: int_res = '0;
    endcase
  end

  // 32-bit word result, opiw and opw
  always_comb
  begin
    word_res = '0;
    case (i_req.funct3)
      F3_ADD:
      begin
        if (is_sub_w)
          word_res = op1_w - op2_w;
        else
          word_res = op1_w + op2_w;
      end
      F3_SLL: word_res = op1_w << shamt_w;
      F3_SRL:
      begin
        if (i_req.alt)
          word_res = $signed(op1_w) >>> shamt_w;
        else
          word_res = op1_w >> shamt_w;
      end
      // no slt/logic ops in the W space
      default: word_res = '0;
    endcase
  end

  // select by class
  always_comb
  begin
    case (i_req.cls)
      CLS_LUI:   o_data = op1;
      CLS_AUIPC: o_data = op1 + op2;
      CLS_OPI,
      CLS_OP:    o_data = int_res;
      // bit 31 of the word fills the upper half
      CLS_OPIW,
      CLS_OPW:   o_data = {{(XLEN-W_XLEN){word_res[W_XLEN-1]}}, word_res};
      CLS_JAL:   o_data = op1;
      CLS_JALR:  o_data = i_req.t1;
      default:   o_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/exe_pkg.sv
// execute stage package
// widths, instruction classes, funct3 codes and stage payload structs
`default_nettype none

package exe_pkg;

  // datapath widths
  localparam int XLEN   = 64;
  localparam int W_XLEN = 32;

  // instruction class, set by decode
  typedef enum logic [3:0] {
    CLS_NONE   = 4'd0,
    CLS_LUI    = 4'd1,
    CLS_AUIPC  = 4'd2,
    CLS_OPI    = 4'd3,
    CLS_OP     = 4'd4,
    CLS_OPIW   = 4'd5,
    CLS_OPW    = 4'd6,
    CLS_JAL    = 4'd7,
    CLS_JALR   = 4'd8,
    CLS_BRANCH = 4'd9,
    CLS_LOAD   = 4'd10,
    CLS_STORE  = 4'd11
  } ex_class_e;

  // alu funct3
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  // srl and sra share this code, alt picks
  localparam logic [2:0] F3_SRL  = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // decoded instruction entering execute
  // lui    op1 = imm
  // auipc  op1 = pc, op2 = imm
  // jal    op1 = link, op2 = target
  // jalr   op1 = base, op2 = offset, t1 = link
  // branch op1/op2 compared, t1 = target
  typedef struct packed {
    ex_class_e        cls;
    logic [2:0]       funct3;
    logic             alt;      // funct7[5]
    logic [XLEN-1:0]  op1;
    logic [XLEN-1:0]  op2;
    logic [XLEN-1:0]  t1;
    logic             memren;
    logic             memwen;
  } ex_req_t;

  // execute result handed to the next stage
  typedef struct packed {
    logic             rd_wen;
    logic [XLEN-1:0]  rd_data;
    logic             pc_jmp;
    logic [XLEN-1:0]  pc_jmpaddr;
    logic             memren;
    logic             memwen;
  } ex_res_t;

endpackage

`default_nettype wire
